// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] inst_t;

  // major opcodes of the supported subset
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;

  // funct3 values
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_addi    = 3'b000;
  localparam logic [2:0] f3_lw      = 3'b010;
  localparam logic [2:0] f3_sw      = 3'b010;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;

  // funct7 values
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;

  // addi x0,x0,0
  localparam inst_t nop_inst = 32'h0000_0013;

endpackage

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  import rv_isa_pkg::*;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_t;

  typedef enum logic [1:0] {
    imm_i = 2'd0,
    imm_s = 2'd1,
    imm_b = 2'd2,
    imm_j = 2'd3
  } imm_sel_t;

  // writeback value source
  typedef enum logic [1:0] {
    res_alu = 2'd0,
    res_mem = 2'd1,
    res_pc4 = 2'd2
  } result_src_t;

  // operand source in execute
  typedef enum logic [1:0] {
    fwd_reg = 2'd0,
    fwd_mem = 2'd1,
    fwd_wb  = 2'd2
  } fwd_sel_t;

  // all zero is a nop with no side effects
  typedef struct packed {
    logic        reg_write;
    logic        mem_req;
    logic        mem_write;
    result_src_t result_src;
    alu_op_t     alu_op;
    logic        alu_src_imm;
    logic        branch;
    logic        branch_ne;
    logic        jump;
  } ctrl_t;

  typedef struct packed {
    reg_idx_t d_rs1;
    reg_idx_t d_rs2;
    reg_idx_t e_rs1;
    reg_idx_t e_rs2;
    reg_idx_t e_rd;
    reg_idx_t m_rd;
    reg_idx_t w_rd;
  } hazard_in_t;

endpackage

`default_nettype wire

// File: hazard.sv
`timescale 1ns/10ps
`default_nettype none

module hazard import pipe_pkg::*; (
  input  hazard_in_t hz,
  input  ctrl_t      e_ctrl,
  input  ctrl_t      m_ctrl,
  input  ctrl_t      w_ctrl,
  input  logic       pc_taken,
  output fwd_sel_t   fwd_a,
  output fwd_sel_t   fwd_b,
  output logic       f_stall,
  output logic       d_stall,
  output logic       d_flush,
  output logic       e_flush
);

  logic m_hit_a;
  logic m_hit_b;
  logic w_hit_a;
  logic w_hit_b;
  logic load_use;

  // memory stage is younger, so it wins over writeback
  assign m_hit_a = m_ctrl.reg_write && hz.m_rd != '0 && hz.m_rd == hz.e_rs1;
  assign m_hit_b = m_ctrl.reg_write && hz.m_rd != '0 && hz.m_rd == hz.e_rs2;
  assign w_hit_a = w_ctrl.reg_write && hz.w_rd != '0 && hz.w_rd == hz.e_rs1;
  assign w_hit_b = w_ctrl.reg_write && hz.w_rd != '0 && hz.w_rd == hz.e_rs2;

  assign fwd_a = m_hit_a ? fwd_mem : (w_hit_a ? fwd_wb : fwd_reg);
  assign fwd_b = m_hit_b ? fwd_mem : (w_hit_b ? fwd_wb : fwd_reg);

  // load in execute feeding the instruction in decode
  assign load_use = (e_ctrl.result_src == res_mem) && hz.e_rd != '0 &&
                    (hz.e_rd == hz.d_rs1 || hz.e_rd == hz.d_rs2);

  always_comb begin
    f_stall = load_use && !pc_taken;
    d_stall = load_use && !pc_taken;
    d_flush = pc_taken;
    e_flush = pc_taken || load_use;
    // a redirect always overrides the stall
    assert (!(d_stall && d_flush));
  end

endmodule

`default_nettype wire

// File: controller.sv
`timescale 1ns/10ps
`default_nettype none

module controller import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  inst_t    d_inst,
  input  logic     e_zero,
  input  logic     e_lt,
  output imm_sel_t d_imm_sel,
  output ctrl_t    e_ctrl,
  output ctrl_t    m_ctrl,
  output ctrl_t    w_ctrl,
  output logic     pc_taken,
  output logic     mreq,
  output logic     write,
  input  logic     d_stall,
  input  logic     e_flush
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  ctrl_t      d_ctrl;

  assign opcode = d_inst[6:0];
  assign funct3 = d_inst[14:12];
  assign funct7 = d_inst[31:25];

  // unknown encodings decode to a nop
  always_comb begin
    d_ctrl    = '0;
    d_imm_sel = imm_i;
    case (opcode)
      opc_op: begin
        d_ctrl.reg_write = (funct7 == f7_base) ||
                           (funct7 == f7_sub && funct3 == f3_add_sub);
        case (funct3)
          f3_slt:  d_ctrl.alu_op = alu_slt;
          f3_or:   d_ctrl.alu_op = alu_or;
          f3_and:  d_ctrl.alu_op = alu_and;
          default: d_ctrl.alu_op = (funct7 == f7_sub) ? alu_sub : alu_add;
        endcase
      end
      opc_op_imm: begin
        d_ctrl.reg_write   = (funct3 == f3_addi);
        d_ctrl.alu_src_imm = 1'b1;
      end
      opc_load: begin
        d_ctrl.reg_write   = (funct3 == f3_lw);
        d_ctrl.mem_req     = (funct3 == f3_lw);
        d_ctrl.result_src  = res_mem;
        d_ctrl.alu_src_imm = 1'b1;
      end
      opc_store: begin
        d_ctrl.mem_req     = (funct3 == f3_sw);
        d_ctrl.mem_write   = (funct3 == f3_sw);
        d_ctrl.alu_src_imm = 1'b1;
        d_imm_sel          = imm_s;
      end
      opc_branch: begin
        d_ctrl.branch    = (funct3 == f3_beq) || (funct3 == f3_bne);
        d_ctrl.branch_ne = (funct3 == f3_bne);
        d_imm_sel        = imm_b;
      end
      opc_jal: begin
        d_ctrl.reg_write  = 1'b1;
        d_ctrl.jump       = 1'b1;
        d_ctrl.result_src = res_pc4;
        d_imm_sel         = imm_j;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      e_ctrl <= '0;
      m_ctrl <= '0;
      w_ctrl <= '0;
    end else begin
      if (e_flush) begin
        e_ctrl <= '0;
      end else if (!d_stall) begin
        e_ctrl <= d_ctrl;
      end
      m_ctrl <= e_ctrl;
      w_ctrl <= m_ctrl;
    end
  end

  assign pc_taken = e_ctrl.jump ||
                    (e_ctrl.branch && (e_ctrl.branch_ne ? !e_zero : e_zero));

  // data port strobes from the memory stage
  assign mreq  = m_ctrl.mem_req;
  assign write = m_ctrl.mem_write;

  assert property (@(posedge clk) disable iff (!rst_n) write |-> mreq);

endmodule

`default_nettype wire

// File: datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  inst_t      idt,
  output word_t      iad,
  input  word_t      read_data,
  output word_t      dad,
  output word_t      write_data,
  output inst_t      d_inst,
  output logic       e_zero,
  output logic       e_lt,
  input  imm_sel_t   d_imm_sel,
  input  ctrl_t      e_ctrl,
  input  ctrl_t      m_ctrl,
  input  ctrl_t      w_ctrl,
  input  logic       pc_taken,
  input  fwd_sel_t   fwd_a,
  input  fwd_sel_t   fwd_b,
  input  logic       f_stall,
  input  logic       d_stall,
  input  logic       d_flush,
  input  logic       e_flush,
  output hazard_in_t hz
);

  word_t    pc;
  word_t    rf [32];
  word_t    d_pc;
  word_t    d_rd1;
  word_t    d_rd2;
  word_t    d_imm;
  reg_idx_t d_rs1;
  reg_idx_t d_rs2;
  reg_idx_t d_rd;
  word_t    e_pc;
  word_t    e_rd1;
  word_t    e_rd2;
  word_t    e_imm;
  reg_idx_t e_rs1;
  reg_idx_t e_rs2;
  reg_idx_t e_rd;
  word_t    e_src_a;
  word_t    e_src_b;
  word_t    e_alu_b;
  word_t    e_alu_y;
  word_t    m_alu;
  word_t    m_wdata;
  word_t    m_pc4;
  word_t    m_fwd;
  reg_idx_t m_rd;
  word_t    w_alu;
  word_t    w_mem;
  word_t    w_pc4;
  word_t    w_result;
  reg_idx_t w_rd;

  // a same-cycle writeback bypasses the array
  function automatic word_t rf_read(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (w_ctrl.reg_write && w_rd == idx) begin
      return w_result;
    end
    return rf[idx];
  endfunction

  function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                    word_t wb_val);
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // fetch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (pc_taken) begin
      pc <= e_pc + e_imm;
    end else if (!f_stall) begin
      pc <= pc + 32'd4;
    end
  end

  assign iad = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_inst <= nop_inst;
    end else if (d_flush) begin
      d_inst <= nop_inst;
    end else if (!d_stall) begin
      d_inst <= idt;
    end
  end

  always_ff @(posedge clk) begin
    if (!d_stall) begin
      d_pc <= pc;
    end
  end

  // decode
  assign d_rs1 = d_inst[19:15];
  assign d_rs2 = d_inst[24:20];
  assign d_rd  = d_inst[11:7];

  always_comb begin
    d_rd1 = rf_read(d_rs1);
    d_rd2 = rf_read(d_rs2);
  end

  always_comb begin
    case (d_imm_sel)
      imm_s:   d_imm = {{20{d_inst[31]}}, d_inst[31:25], d_inst[11:7]};
      imm_b:   d_imm = {{19{d_inst[31]}}, d_inst[31], d_inst[7], d_inst[30:25],
                        d_inst[11:8], 1'b0};
      imm_j:   d_imm = {{11{d_inst[31]}}, d_inst[31], d_inst[19:12], d_inst[20],
                        d_inst[30:21], 1'b0};
      default: d_imm = {{20{d_inst[31]}}, d_inst[31:20]};
    endcase
  end

  always_ff @(posedge clk) begin
    e_pc  <= d_pc;
    e_rd1 <= d_rd1;
    e_rd2 <= d_rd2;
    e_imm <= d_imm;
    e_rs1 <= d_rs1;
    e_rs2 <= d_rs2;
  end

  // bubble carries rd zero so nothing matches it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      e_rd <= '0;
    end else if (e_flush) begin
      e_rd <= '0;
    end else begin
      e_rd <= d_rd;
    end
  end

  // execute
  assign e_src_a = fwd_mux(fwd_a, e_rd1, m_fwd, w_result);
  assign e_src_b = fwd_mux(fwd_b, e_rd2, m_fwd, w_result);
  assign e_alu_b = e_ctrl.alu_src_imm ? e_imm : e_src_b;
  assign e_zero  = (e_src_a == e_alu_b);
  assign e_lt    = ($signed(e_src_a) < $signed(e_alu_b));

  always_comb begin
    case (e_ctrl.alu_op)
      alu_sub: e_alu_y = e_src_a - e_alu_b;
      alu_and: e_alu_y = e_src_a & e_alu_b;
      alu_or:  e_alu_y = e_src_a | e_alu_b;
      alu_slt: e_alu_y = {31'd0, e_lt};
      default: e_alu_y = e_src_a + e_alu_b;
    endcase
  end

  always_ff @(posedge clk) begin
    m_alu   <= e_alu_y;
    m_wdata <= e_src_b;
    m_pc4   <= e_pc + 32'd4;
    m_rd    <= e_rd;
  end

  // memory
  assign dad        = m_alu;
  assign write_data = m_wdata;
  assign m_fwd      = (m_ctrl.result_src == res_pc4) ? m_pc4 : m_alu;

  always_ff @(posedge clk) begin
    w_alu <= m_alu;
    w_mem <= read_data;
    w_pc4 <= m_pc4;
    w_rd  <= m_rd;
  end

  // writeback
  always_comb begin
    case (w_ctrl.result_src)
      res_mem: w_result = w_mem;
      res_pc4: w_result = w_pc4;
      default: w_result = w_alu;
    endcase
  end

  always_ff @(posedge clk) begin
    if (w_ctrl.reg_write && w_rd != '0) begin
      rf[w_rd] <= w_result;
    end
  end

  assign hz = '{d_rs1: d_rs1, d_rs2: d_rs2, e_rs1: e_rs1, e_rs2: e_rs2,
                e_rd: e_rd, m_rd: m_rd, w_rd: w_rd};

  // writeback into x0 must not leak through the bypass
  assert property (@(posedge clk) disable iff (!rst_n)
    (w_ctrl.reg_write && w_rd == '0 && d_rs1 == '0) |-> d_rd1 == '0);

endmodule

`default_nettype wire

// File: pipeline_top.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_top import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output word_t iad,
  input  inst_t idt,
  output logic  mreq,
  output logic  write,
  output word_t dad,
  output word_t write_data,
  input  word_t read_data
);

  // datapath to controller
  inst_t      d_inst;
  logic       e_zero;
  logic       e_lt;
  hazard_in_t hz;

  // controller to datapath and hazard
  imm_sel_t d_imm_sel;
  ctrl_t    e_ctrl;
  ctrl_t    m_ctrl;
  ctrl_t    w_ctrl;
  logic     pc_taken;

  // hazard outputs
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  logic     f_stall;
  logic     d_stall;
  logic     d_flush;
  logic     e_flush;

  datapath datapath (
    .clk(clk), .rst_n(rst_n),
    .idt(idt), .iad(iad), .read_data(read_data),
    .dad(dad), .write_data(write_data),
    .d_inst(d_inst), .e_zero(e_zero), .e_lt(e_lt),
    .d_imm_sel(d_imm_sel), .e_ctrl(e_ctrl), .m_ctrl(m_ctrl), .w_ctrl(w_ctrl),
    .pc_taken(pc_taken), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .f_stall(f_stall), .d_stall(d_stall), .d_flush(d_flush), .e_flush(e_flush),
    .hz(hz)
  );

  controller controller (
    .clk(clk), .rst_n(rst_n),
    .d_inst(d_inst), .e_zero(e_zero), .e_lt(e_lt),
    .d_imm_sel(d_imm_sel), .e_ctrl(e_ctrl), .m_ctrl(m_ctrl), .w_ctrl(w_ctrl),
    .pc_taken(pc_taken), .mreq(mreq), .write(write),
    .d_stall(d_stall), .e_flush(e_flush)
  );

  hazard hazard (
    .hz(hz), .e_ctrl(e_ctrl), .m_ctrl(m_ctrl), .w_ctrl(w_ctrl),
    .pc_taken(pc_taken), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .f_stall(f_stall), .d_stall(d_stall), .d_flush(d_flush), .e_flush(e_flush)
  );

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // release a little after the tenth rising edge
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_ref_model.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ref_model import rv_isa_pkg::*; (
  input  logic       start,
  input  inst_t      prog [128],
  input  logic [2:0] prog_tag [128],
  input  word_t      ram_init [64],
  output word_t      exp_addr [64],
  output word_t      exp_data [64],
  output logic [2:0] exp_tag [64],
  output logic [6:0] exp_count,
  output logic       ready
);

  // jal x0,0 marks the end of the program
  localparam inst_t halt_inst = 32'h0000_006f;

  initial begin
    word_t      regs [32];
    word_t      mem [64];
    word_t      pc;
    word_t      a;
    word_t      b;
    word_t      addr;
    word_t      res;
    word_t      i_imm;
    word_t      s_imm;
    word_t      b_imm;
    word_t      j_imm;
    inst_t      in;
    logic [7:0] k;
    logic [6:0] cnt;
    int         steps;
    ready = 1'b0;
    exp_count = '0;
    wait (start);
    for (k = 0; k < 32; k++) begin
      regs[k[4:0]] = '0;
    end
    for (k = 0; k < 64; k++) begin
      mem[k[5:0]] = ram_init[k[5:0]];
    end
    pc = '0;
    cnt = '0;
    steps = 0;
    while (steps < 1000 && prog[pc[8:2]] != halt_inst) begin
      in = prog[pc[8:2]];
      a = regs[in[19:15]];
      b = regs[in[24:20]];
      i_imm = {{20{in[31]}}, in[31:20]};
      s_imm = {{20{in[31]}}, in[31:25], in[11:7]};
      b_imm = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
      j_imm = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
      res = '0;
      case (in[6:0])
        opc_op: begin
          case (in[14:12])
            f3_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3_or:   res = a | b;
            f3_and:  res = a & b;
            default: res = (in[31:25] == f7_sub) ? a - b : a + b;
          endcase
          if (in[11:7] != 5'd0) regs[in[11:7]] = res;
          pc = pc + 32'd4;
        end
        opc_op_imm: begin
          if (in[11:7] != 5'd0) regs[in[11:7]] = a + i_imm;
          pc = pc + 32'd4;
        end
        opc_load: begin
          addr = a + i_imm;
          if (in[11:7] != 5'd0) regs[in[11:7]] = mem[addr[7:2]];
          pc = pc + 32'd4;
        end
        opc_store: begin
          addr = a + s_imm;
          mem[addr[7:2]] = b;
          exp_addr[cnt[5:0]] = addr;
          exp_data[cnt[5:0]] = b;
          exp_tag[cnt[5:0]] = prog_tag[pc[8:2]];
          cnt = cnt + 7'd1;
          pc = pc + 32'd4;
        end
        opc_branch: begin
          if ((in[14:12] == f3_bne) ? (a != b) : (a == b)) begin
            pc = pc + b_imm;
          end else begin
            pc = pc + 32'd4;
          end
        end
        opc_jal: begin
          if (in[11:7] != 5'd0) regs[in[11:7]] = pc + 32'd4;
          pc = pc + j_imm;
        end
        default: pc = pc + 32'd4;
      endcase
      steps++;
    end
    exp_count = cnt;
    ready = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top import rv_isa_pkg::*; ();

  logic       clk;
  logic       rst_n;
  word_t      iad;
  inst_t      idt;
  logic       mreq;
  logic       write;
  word_t      dad;
  word_t      write_data;
  word_t      read_data;
  inst_t      rom [128];
  logic [2:0] rom_tag [128];
  word_t      ram [64];
  word_t      ram_init [64];
  word_t      exp_addr [64];
  word_t      exp_data [64];
  logic [2:0] exp_tag [64];
  logic [6:0] exp_count;
  logic [6:0] store_idx;
  logic       start;
  logic       ready;
  logic [7:0] n;
  logic [2:0] cur_tag;
  int         seed;
  int         fails [8];
  int         cycles;
  int         limit;
  int         after_rst;

  tb_clock clock0 (.clk(clk), .rst_n(rst_n));

  pipeline_top dut0 (
    .clk(clk), .rst_n(rst_n), .iad(iad), .idt(idt),
    .mreq(mreq), .write(write), .dad(dad), .write_data(write_data),
    .read_data(read_data)
  );

  tb_ref_model ref0 (
    .start(start), .prog(rom), .prog_tag(rom_tag), .ram_init(ram_init),
    .exp_addr(exp_addr), .exp_data(exp_data), .exp_tag(exp_tag),
    .exp_count(exp_count), .ready(ready)
  );

  // both memories answer in the same cycle
  assign idt = (iad[31:9] == '0) ? rom[iad[8:2]] : nop_inst;
  assign read_data = ram[dad[7:2]];

  always @(posedge clk) begin
    logic [7:0] k;
    if (!rst_n) begin
      for (k = 0; k < 64; k++) begin
        ram[k[5:0]] <= ram_init[k[5:0]];
      end
    end else if (mreq && write) begin
      ram[dad[7:2]] <= write_data;
    end
  end

  function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, reg_idx_t rd,
                                  logic [6:0] opc);
    return {imm, rs1, 3'b000 | ((opc == opc_load) ? f3_lw : f3_addi), rd, opc};
  endfunction

  function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, f3_sw, imm[4:0], opc_store};
  endfunction

  function automatic inst_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic inst_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  function automatic logic [11:0] rand_imm();
    logic [31:0] tmp;
    tmp = $random(seed);
    return tmp[11:0];
  endfunction

  function automatic string test_name(logic [2:0] t);
    case (t)
      3'd1:    return "alu operations";
      3'd2:    return "forwarding";
      3'd3:    return "load-use stall";
      3'd4:    return "branches and jumps";
      3'd5:    return "register zero";
      default: return "reset state";
    endcase
  endfunction

  task automatic emit(inst_t inst);
    rom[n[6:0]] = inst;
    rom_tag[n[6:0]] = cur_tag;
    n = n + 8'd1;
  endtask

  task automatic build_program();
    logic [7:0] k;
    word_t      a;
    for (k = 0; k < 128; k++) begin
      rom[k[6:0]] = nop_inst;
      rom_tag[k[6:0]] = 3'd0;
    end
    // pattern spans every address bit
    for (k = 0; k < 64; k++) begin
      a = {24'd0, k[5:0], 2'b00};
      ram_init[k[5:0]] = (a * 32'h9e37_79b1) ^ 32'h5a3c_0f0f;
    end
    n = '0;
    cur_tag = 3'd1;
    emit(enc_i(rand_imm(), 0, 1, opc_op_imm));
    emit(enc_i(rand_imm(), 0, 2, opc_op_imm));
    emit(enc_r(f7_base, 2, 1, f3_add_sub, 3));
    emit(enc_s(0, 3, 0));
    emit(enc_r(f7_sub, 2, 1, f3_add_sub, 4));
    emit(enc_s(4, 4, 0));
    emit(enc_r(f7_base, 2, 1, f3_and, 5));
    emit(enc_s(8, 5, 0));
    emit(enc_r(f7_base, 2, 1, f3_or, 6));
    emit(enc_s(12, 6, 0));
    emit(enc_r(f7_base, 2, 1, f3_slt, 7));
    emit(enc_s(16, 7, 0));
    emit(enc_i(rand_imm(), 1, 8, opc_op_imm));
    emit(enc_s(20, 8, 0));
    // distance 1 then distance 2
    cur_tag = 3'd2;
    emit(enc_i(rand_imm(), 0, 9, opc_op_imm));
    emit(enc_r(f7_base, 9, 9, f3_add_sub, 10));
    emit(enc_s(24, 10, 0));
    emit(enc_i(rand_imm(), 0, 12, opc_op_imm));
    emit(enc_i(rand_imm(), 0, 13, opc_op_imm));
    emit(enc_r(f7_base, 2, 12, f3_add_sub, 14));
    emit(enc_s(28, 14, 0));
    cur_tag = 3'd3;
    emit(enc_i(32, 0, 15, opc_load));
    emit(enc_r(f7_base, 1, 15, f3_add_sub, 16));
    emit(enc_s(36, 16, 0));
    emit(enc_i(0, 0, 17, opc_load));
    emit(enc_r(f7_base, 17, 17, f3_add_sub, 18));
    emit(enc_s(40, 18, 0));
    // marker stores sit in the flushed slots
    cur_tag = 3'd4;
    emit(enc_i(12'h7ad, 0, 21, opc_op_imm));
    emit(enc_b(12, 1, 1, f3_beq));
    emit(enc_s(200, 21, 0));
    emit(enc_s(204, 21, 0));
    emit(enc_s(44, 1, 0));
    emit(enc_b(12, 1, 1, f3_bne));
    emit(enc_s(48, 2, 0));
    emit(enc_s(52, 3, 0));
    emit(enc_b(12, 2, 1, f3_bne));
    emit(enc_s(208, 21, 0));
    emit(enc_s(212, 21, 0));
    emit(enc_s(56, 2, 0));
    emit(enc_b(12, 2, 1, f3_beq));
    emit(enc_s(60, 4, 0));
    emit(enc_s(64, 5, 0));
    emit(enc_j(12, 22));
    emit(enc_s(216, 21, 0));
    emit(enc_s(220, 21, 0));
    emit(enc_s(68, 22, 0));
    cur_tag = 3'd5;
    emit(enc_i(12'h123, 0, 0, opc_op_imm));
    emit(enc_r(f7_base, 2, 1, f3_add_sub, 0));
    emit(enc_s(72, 0, 0));
    cur_tag = 3'd0;
    emit(enc_j(0, 0));
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      store_idx <= '0;
      after_rst <= 0;
    end else begin
      if (mreq && write) store_idx <= store_idx + 7'd1;
      if (after_rst < 1000) after_rst <= after_rst + 1;
    end
  end

  // every store must match the next expected entry
  assert property (@(posedge clk) disable iff (!rst_n)
    (mreq && write) |-> (store_idx < exp_count && dad == exp_addr[store_idx[5:0]] &&
                         write_data == exp_data[store_idx[5:0]]))
  else begin
    if ($sampled(store_idx) < exp_count) begin
      $display("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h",
               $time, $sampled(store_idx), $sampled(write_data), $sampled(dad),
               exp_data[$sampled(store_idx[5:0])], exp_addr[$sampled(store_idx[5:0])]);
      fails[exp_tag[$sampled(store_idx[5:0])]]++;
    end else begin
      $display("MISMATCH at %0t: unexpected store of %h to %h", $time,
               $sampled(write_data), $sampled(dad));
      fails[4]++;
    end
  end

  assert property (@(posedge clk) (!rst_n || after_rst == 0) |->
    (iad == '0 && !mreq && !write))
  else begin
    $display("MISMATCH at %0t: iad %h mreq %b write %b in reset window",
             $time, $sampled(iad), $sampled(mreq), $sampled(write));
    fails[6]++;
  end

  // cycle budget counted from reset release
  always @(posedge clk) begin
    if (rst_n) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
        $display("timeout: the program never reached its final store");
        $display("Test failed");
        $finish;
      end
    end
  end

  initial begin
    int         total;
    int         passed;
    logic [3:0] t;
    seed = 71211;
    start = 1'b0;
    cycles = 0;
    limit = 100000;
    for (t = 0; t < 8; t++) begin
      fails[t[2:0]] = 0;
    end
    build_program();
    limit = 4 * int'(n) + 50;
    #1 start = 1'b1;
    wait (ready);
    wait (rst_n);
    while (store_idx < exp_count) @(posedge clk);
    // watch for stray stores after the last one
    repeat (20) @(posedge clk);
    total = 0;
    passed = 0;
    for (t = 1; t < 7; t++) begin
      $display("test %0d %s: %s", t, test_name(t[2:0]),
               (fails[t[2:0]] == 0) ? "PASS" : "FAIL");
      if (fails[t[2:0]] == 0) passed++;
      total += fails[t[2:0]];
    end
    $display("tests passed %0d, tests failed %0d, errors %0d, stores %0d",
             passed, 6 - passed, total, exp_count);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
rv_isa_pkg.sv
pipe_pkg.sv
hazard.sv
controller.sv
datapath.sv
pipeline_top.sv
tb_clock.sv
tb_ref_model.sv
tb_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module tb_top &&
./obj_dir/Vtb_top | tee /dev/stderr | grep -q "Test completed successfully" ||
{ echo "simulation did not pass"; exit 1; }
